/* src/issue_pkg.sv */
// Issue stage package
// Widths, unit codes, FUST row types and the row state enum
package issue_pkg;

    typedef logic [31:0] word_t;      // Data word
    typedef logic [4:0]  regbits_t;   // Scalar register number
    typedef logic [3:0]  mregbits_t;  // Matrix register number
    typedef logic [2:0]  tag_t;       // Producer tag, zero when available
    typedef logic [3:0]  age_t;       // Row age, saturates at 15
    typedef logic [1:0]  fu_t;        // Unit code, doubles as row index

    localparam fu_t FU_ALU    = 2'd0;
    localparam fu_t FU_LD_ST  = 2'd1;
    localparam fu_t FU_BRANCH = 2'd2;
    localparam fu_t FU_MATRIX = 2'd3;

    localparam int NUM_ROWS   = 4;
    localparam int NUM_S_ROWS = 3;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,   // Loaded, tags may still be pending
        FUST_RDY     // Tags cleared, waiting for a grant
    } fust_state_e;

    typedef struct packed {
        logic [7:0] op;
        regbits_t   rd;
        regbits_t   rs1;
        regbits_t   rs2;
        tag_t       t1;
        tag_t       t2;
    } fust_s_row_t;

    typedef struct packed {
        logic [7:0] op;
        mregbits_t  md;
        mregbits_t  ms1;
        mregbits_t  ms2;
        tag_t       t1;
        tag_t       t2;
    } fust_m_row_t;

    // Only the side selected by fu carries meaning
    typedef struct packed {
        fu_t         fu;
        fust_s_row_t s;
        fust_m_row_t m;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        logic     reg_en;   // Also write the scalar register file
        regbits_t rd;
        word_t    wdata;
    } wb_t;

    typedef struct packed {
        fu_t        fu;
        logic [7:0] op;
        regbits_t   rd;
        mregbits_t  md;
        mregbits_t  ms1;
        mregbits_t  ms2;
        word_t      rdat1;
        word_t      rdat2;
    } issue_t;

endpackage

/* src/regfile.sv */
// Scalar register file, one write port and two forwarding read ports
module regfile import issue_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     wen,
    input  regbits_t wsel,
    input  word_t    wdata,
    input  regbits_t rsel1,
    input  regbits_t rsel2,
    output word_t    rdat1,
    output word_t    rdat2
);

    word_t regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wsel != '0) begin
            regs[wsel] <= wdata;
        end
    end

    // Register 0 is hardwired, a same-cycle write is forwarded
    always_comb begin
        if (rsel1 == '0)
            rdat1 = '0;
        else if (wen && wsel == rsel1)
            rdat1 = wdata;
        else
            rdat1 = regs[rsel1];

        if (rsel2 == '0)
            rdat2 = '0;
        else if (wen && wsel == rsel2)
            rdat2 = wdata;
        else
            rdat2 = regs[rsel2];
    end

endmodule

/* src/fust_scalar.sv */
// Scalar FUST with ALU, LD_ST and BRANCH rows
// Dispatch write, writeback tag clearing, ready flags, free on grant
module fust_scalar import issue_pkg::*; (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         en,
    input  fu_t                          fu,
    input  fust_s_row_t                  row_in,
    input  wb_t                          wb,
    input  logic [NUM_S_ROWS-1:0]        grant,
    output fust_s_row_t [NUM_S_ROWS-1:0] rows,
    output logic [NUM_S_ROWS-1:0]        rdy,
    output fust_state_e [NUM_S_ROWS-1:0] state
);

    // Row payload, tags are cleared by matching broadcasts
    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_S_ROWS; i++) begin
            if (en && fu == fu_t'(i)) begin
                rows[i] <= row_in;
                // Broadcast in the dispatch cycle still counts
                if (wb.valid && row_in.t1 == wb.tag)
                    rows[i].t1 <= '0;
                if (wb.valid && row_in.t2 == wb.tag)
                    rows[i].t2 <= '0;
            end else if (wb.valid) begin
                if (rows[i].t1 == wb.tag)
                    rows[i].t1 <= '0;
                if (rows[i].t2 == wb.tag)
                    rows[i].t2 <= '0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_S_ROWS; i++) begin
            rdy[i] = (state[i] != FUST_EMPTY) && (rows[i].t1 == '0) && (rows[i].t2 == '0);
        end
    end

    // Row state FSMs
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_S_ROWS; i++) begin
                state[i] <= FUST_EMPTY;
            end
        end else begin
            for (int i = 0; i < NUM_S_ROWS; i++) begin
                case (state[i])
                    FUST_EMPTY: begin
                        if (en && fu == fu_t'(i))
                            state[i] <= FUST_WAIT;
                    end
                    FUST_WAIT: begin
                        if (grant[i])
                            state[i] <= FUST_EMPTY;
                        else if (rdy[i])
                            state[i] <= FUST_RDY;   // Tags all clear
                    end
                    FUST_RDY: begin
                        if (grant[i])
                            state[i] <= FUST_EMPTY;
                    end
                    default: state[i] <= FUST_EMPTY;
                endcase
            end
        end
    end

endmodule

/* src/fust_matrix.sv */
// Matrix load/store FUST, single row
module fust_matrix import issue_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        en,
    input  fust_m_row_t row_in,
    input  wb_t         wb,
    input  logic        grant,
    output fust_m_row_t row,
    output logic        rdy,
    output fust_state_e state
);

    always_ff @(posedge CLK) begin
        if (en) begin
            row <= row_in;
            if (wb.valid && row_in.t1 == wb.tag)
                row.t1 <= '0;
            if (wb.valid && row_in.t2 == wb.tag)
                row.t2 <= '0;
        end else if (wb.valid) begin
            if (row.t1 == wb.tag)
                row.t1 <= '0;
            if (row.t2 == wb.tag)
                row.t2 <= '0;
        end
    end

    assign rdy = (state != FUST_EMPTY) && (row.t1 == '0) && (row.t2 == '0);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= FUST_EMPTY;
        end else begin
            case (state)
                FUST_EMPTY: if (en) state <= FUST_WAIT;
                FUST_WAIT: begin
                    if (grant)
                        state <= FUST_EMPTY;
                    else if (rdy)
                        state <= FUST_RDY;
                end
                FUST_RDY:   if (grant) state <= FUST_EMPTY;
                default:    state <= FUST_EMPTY;
            endcase
        end
    end

endmodule

/* src/oldest_arbiter.sv */
// Oldest-first arbiter over the FUST rows
// Per-row age counters and a grant gated by the output slot
module oldest_arbiter import issue_pkg::*; (
    input  logic                       CLK,
    input  logic                       nRST,
    input  fust_state_e [NUM_ROWS-1:0] state,
    input  logic [NUM_ROWS-1:0]        rdy,
    input  logic                       slot_free,
    output logic [NUM_ROWS-1:0]        grant,
    output logic                       grant_valid
);

    age_t cnt [NUM_ROWS];   // Preloaded to 1 while the row is empty
    age_t age [NUM_ROWS];
    age_t best_age;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_ROWS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (state[i] == FUST_EMPTY)
                    cnt[i] <= age_t'(1);
                else if (cnt[i] != '1)
                    cnt[i] <= cnt[i] + age_t'(1);   // Saturate at 15
            end
        end
    end

    // An empty row has no age
    always_comb begin
        for (int i = 0; i < NUM_ROWS; i++) begin
            age[i] = (state[i] == FUST_EMPTY) ? '0 : cnt[i];
        end
    end

    // Strictly greater wins, so the lowest index takes a tie
    always_comb begin
        grant    = '0;
        best_age = '0;
        if (slot_free) begin
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (rdy[i] && (grant == '0 || age[i] > best_age)) begin
                    grant    = '0;
                    grant[i] = 1'b1;
                    best_age = age[i];
                end
            end
        end
    end

    assign grant_valid = |grant;

endmodule

/* src/issue_out.sv */
// Issue output stage
// Builds the issued instruction from the granted row and holds it under valid/ready
module issue_out import issue_pkg::*; (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic [NUM_ROWS-1:0]          grant,
    input  logic                         grant_valid,
    input  fust_s_row_t [NUM_S_ROWS-1:0] s_rows,
    input  fust_m_row_t                  m_row,
    input  word_t                        rdat1,
    input  word_t                        rdat2,
    output regbits_t                     rsel1,
    output regbits_t                     rsel2,
    input  logic                         issue_ready,
    output logic                         issue_valid,
    output issue_t                       issue,
    output logic                         slot_free
);

    fu_t    sel_fu;
    issue_t n_issue;

    // One-hot grant to unit code
    always_comb begin
        case (grant)
            4'b0010: sel_fu = FU_LD_ST;
            4'b0100: sel_fu = FU_BRANCH;
            4'b1000: sel_fu = FU_MATRIX;
            default: sel_fu = FU_ALU;
        endcase
    end

    always_comb begin
        rsel1   = '0;
        rsel2   = '0;
        n_issue = '0;
        n_issue.fu = sel_fu;
        if (grant_valid && sel_fu == FU_MATRIX) begin
            n_issue.op  = m_row.op;   // Matrix operands bypass the scalar file
            n_issue.md  = m_row.md;
            n_issue.ms1 = m_row.ms1;
            n_issue.ms2 = m_row.ms2;
        end else if (grant_valid) begin
            rsel1         = s_rows[sel_fu].rs1;
            rsel2         = s_rows[sel_fu].rs2;
            n_issue.op    = s_rows[sel_fu].op;
            n_issue.rd    = s_rows[sel_fu].rd;
            n_issue.rdat1 = rdat1;
            n_issue.rdat2 = rdat2;
        end
    end

    assign slot_free = !issue_valid || issue_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            issue_valid <= 1'b0;
        else if (grant_valid)
            issue_valid <= 1'b1;
        else if (issue_ready)
            issue_valid <= 1'b0;   // Taken with nothing behind it
    end

    always_ff @(posedge CLK) begin
        if (grant_valid)
            issue <= n_issue;
    end

endmodule

/* src/issue_top.sv */
// Issue stage top: FUSTs, oldest-first arbiter, register file, output stage
module issue_top import issue_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    input  wb_t       wb,
    output logic      issue_valid,
    output issue_t    issue,
    input  logic      issue_ready
);

    fust_s_row_t [NUM_S_ROWS-1:0] s_rows;
    fust_m_row_t                  m_row;
    fust_state_e [NUM_S_ROWS-1:0] s_state;
    fust_state_e                  m_state;
    fust_state_e [NUM_ROWS-1:0]   row_state;
    logic [NUM_S_ROWS-1:0]        s_rdy;
    logic                         m_rdy;
    logic [NUM_ROWS-1:0]          grant;
    logic                         grant_valid;
    logic                         slot_free;
    logic                         s_en, m_en;
    regbits_t                     rsel1, rsel2;
    word_t                        rdat1, rdat2;

    always_comb begin
        row_state[NUM_S_ROWS-1:0] = s_state;
        row_state[FU_MATRIX]      = m_state;
    end

    // Dispatch only into an empty row of its unit
    assign dispatch_ready = (row_state[dispatch.fu] == FUST_EMPTY);
    assign s_en = dispatch_valid && dispatch_ready && (dispatch.fu != FU_MATRIX);
    assign m_en = dispatch_valid && dispatch_ready && (dispatch.fu == FU_MATRIX);

    fust_scalar u_fust_s (.CLK, .nRST, .en(s_en), .fu(dispatch.fu), .row_in(dispatch.s),
        .wb, .grant(grant[NUM_S_ROWS-1:0]), .rows(s_rows), .rdy(s_rdy), .state(s_state));

    fust_matrix u_fust_m (.CLK, .nRST, .en(m_en), .row_in(dispatch.m), .wb,
        .grant(grant[FU_MATRIX]), .row(m_row), .rdy(m_rdy), .state(m_state));

    oldest_arbiter u_arb (.CLK, .nRST, .state(row_state), .rdy({m_rdy, s_rdy}),
        .slot_free, .grant, .grant_valid);

    regfile u_rf (.CLK, .nRST, .wen(wb.valid && wb.reg_en), .wsel(wb.rd), .wdata(wb.wdata),
        .rsel1, .rsel2, .rdat1, .rdat2);

    issue_out u_out (.CLK, .nRST, .grant, .grant_valid, .s_rows, .m_row, .rdat1, .rdat2,
        .rsel1, .rsel2, .issue_ready, .issue_valid, .issue, .slot_free);

endmodule

/* verif/tb_clock.sv */
// Testbench clock and reset, 40 ns period, reset low for 3 cycles
module tb_clock (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (3) @(negedge CLK);
        nRST = 1'b1;   // Released on a falling edge
    end

endmodule

/* verif/issue_sva.sv */
// Bound assertions on the issue handshake, the grant and the state after reset
module issue_sva import issue_pkg::*; (
    input logic                CLK,
    input logic                nRST,
    input logic                issue_valid,
    input logic                issue_ready,
    input issue_t              issue,
    input logic [NUM_ROWS-1:0] grant
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_fail = 0;   // Failed assertions so far

    // A stalled issue keeps its contents
    a_hold: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue))
        else begin
            n_fail++;
            $error("issue changed while stalled");
        end

    a_grant: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(grant))
        else begin
            n_fail++;
            $error("grant is not one-hot");
        end

    a_reset: assert property (@(posedge CLK) $rose(nRST) |-> !issue_valid)
        else begin
            n_fail++;
            $error("issue_valid high right after reset");
        end

endmodule

bind issue_top issue_sva u_sva (.CLK, .nRST, .issue_valid, .issue_ready, .issue, .grant);

/* verif/issue_tb.sv */
// Issue stage testbench
// Directed tests for operands, tag wakeup, oldest-first order and back-pressure
module issue_tb import issue_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;

    logic      CLK, nRST;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    wb_t       wb;
    logic      issue_valid;
    issue_t    issue;
    logic      issue_ready;
    word_t     rng;
    int        n_err, n_timeout;

    tb_clock u_clk (.CLK, .nRST);

    issue_top UUT (.CLK, .nRST, .dispatch_valid, .dispatch, .dispatch_ready, .wb,
        .issue_valid, .issue, .issue_ready);

    function automatic word_t xorshift(input word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic dispatch_t build_scalar(input fu_t fu, input logic [7:0] op,
        input regbits_t rd, input regbits_t rs1, input regbits_t rs2, input tag_t t1);
        dispatch_t d;
        d = '0;
        d.fu = fu;
        d.s.op = op;
        d.s.rd = rd;
        d.s.rs1 = rs1;
        d.s.rs2 = rs2;
        d.s.t1 = t1;
        return d;
    endfunction

    function automatic dispatch_t build_matrix(input logic [7:0] op, input mregbits_t md,
        input mregbits_t ms1, input mregbits_t ms2);
        dispatch_t d;
        d = '0;
        d.fu = FU_MATRIX;
        d.m.op = op;
        d.m.md = md;
        d.m.ms1 = ms1;
        d.m.ms2 = ms2;
        return d;
    endfunction

    // Holds valid until the unit's row accepts, returns on the next falling edge
    task automatic send_dispatch(input dispatch_t d);
        int n;
        dispatch = d;
        dispatch_valid = 1'b1;
        #1;
        n = 0;
        while (!dispatch_ready && n < TIMEOUT) begin
            @(negedge CLK);
            #1;
            n++;
        end
        if (!dispatch_ready) begin
            $display("Dispatch to unit %0d was never accepted", d.fu);
            n_timeout++;
        end
        @(negedge CLK);
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input regbits_t rd, input word_t data, input tag_t tag);
        wb.valid = 1'b1;
        wb.tag = tag;
        wb.reg_en = 1'b1;
        wb.rd = rd;
        wb.wdata = data;
        @(negedge CLK);
        wb = '0;
    endtask

    // Expects issue_ready high, takes one issue and steps past its transfer edge
    task automatic wait_issue(output issue_t got, output int cycles);
        got = '0;
        cycles = 0;
        while (!issue_valid && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (issue_valid) begin
            got = issue;
        end else begin
            $display("No instruction was issued in time");
            n_timeout++;
        end
        @(negedge CLK);
    endtask

    task automatic test_reset();
        if (issue_valid !== 1'b0) begin
            $display("ERROR issue_valid got %h expected 0", issue_valid);
            n_err++;
        end
        for (int f = 0; f < NUM_ROWS; f++) begin
            dispatch.fu = fu_t'(f);
            #1;
            if (dispatch_ready !== 1'b1) begin
                $display("ERROR dispatch_ready (fu %0d) got %h expected 1", f, dispatch_ready);
                n_err++;
            end
        end
        dispatch = '0;
        @(negedge CLK);
    endtask

    task automatic test_operands();
        word_t  w1, w2;
        issue_t got;
        int     cyc;
        rng = xorshift(rng);
        w1 = rng;
        rng = xorshift(rng);
        w2 = rng;
        broadcast(5'd3, w1, 3'd0);
        broadcast(5'd7, w2, 3'd0);
        send_dispatch(build_scalar(FU_ALU, 8'h21, 5'd9, 5'd3, 5'd7, 3'd0));
        wait_issue(got, cyc);
        if (cyc != 1) begin
            $display("ALU issue took %0d cycles instead of 2", cyc + 1);
            n_err++;
        end
        if (got.fu !== FU_ALU || got.op !== 8'h21 || got.rd !== 5'd9) begin
            $display("ERROR issue.fu/op/rd got %h/%h/%h expected 0/21/09", got.fu, got.op, got.rd);
            n_err++;
        end
        if (got.rdat1 !== w1 || got.rdat2 !== w2) begin
            $display("ERROR issue.rdat1/rdat2 got %h/%h expected %h/%h",
                got.rdat1, got.rdat2, w1, w2);
            n_err++;
        end
    endtask

    task automatic test_tag_wait();
        word_t  w;
        issue_t got;
        int     cyc;
        send_dispatch(build_scalar(FU_LD_ST, 8'h42, 5'd4, 5'd12, 5'd0, 3'd5));
        repeat (5) begin
            if (issue_valid) begin
                $display("LD_ST instruction issued while its tag was pending");
                n_err++;
            end
            @(negedge CLK);
        end
        rng = xorshift(rng);
        w = rng;
        broadcast(5'd12, w, 3'd5);   // Wakes the row and writes its operand
        wait_issue(got, cyc);
        if (got.fu !== FU_LD_ST || got.rdat1 !== w || got.rdat2 !== '0) begin
            $display("ERROR issue.fu/rdat1/rdat2 got %h/%h/%h expected 1/%h/0",
                got.fu, got.rdat1, got.rdat2, w);
            n_err++;
        end
    endtask

    task automatic test_oldest_first();
        issue_t got;
        int     cyc;
        fu_t    order [4];
        order = '{FU_LD_ST, FU_BRANCH, FU_ALU, FU_MATRIX};
        issue_ready = 1'b0;
        send_dispatch(build_scalar(FU_LD_ST, 8'h50, 5'd1, 5'd0, 5'd0, 3'd0));   // Fills the slot
        send_dispatch(build_scalar(FU_BRANCH, 8'h51, 5'd0, 5'd3, 5'd7, 3'd0));
        send_dispatch(build_scalar(FU_ALU, 8'h52, 5'd5, 5'd7, 5'd3, 3'd0));
        send_dispatch(build_matrix(8'h53, 4'd2, 4'd9, 4'd14));
        issue_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            wait_issue(got, cyc);
            if (got.fu !== order[i]) begin
                $display("ERROR issue.fu (issue %0d) got %h expected %h", i, got.fu, order[i]);
                n_err++;
            end
        end
        if (got.op !== 8'h53 || got.md !== 4'd2 || got.ms1 !== 4'd9 || got.ms2 !== 4'd14) begin
            $display("ERROR issue.op/md/ms1/ms2 got %h/%h/%h/%h expected 53/2/9/e",
                got.op, got.md, got.ms1, got.ms2);
            n_err++;
        end
    endtask

    task automatic test_backpressure();
        issue_t held, got;
        int     cyc;
        issue_ready = 1'b0;
        send_dispatch(build_scalar(FU_ALU, 8'h61, 5'd2, 5'd3, 5'd0, 3'd0));
        send_dispatch(build_scalar(FU_ALU, 8'h62, 5'd2, 5'd7, 5'd0, 3'd0));
        held = issue;
        if (issue_valid !== 1'b1 || held.op !== 8'h61) begin
            $display("ERROR issue_valid/issue.op got %h/%h expected 1/61", issue_valid, held.op);
            n_err++;
        end
        dispatch = build_scalar(FU_ALU, 8'h63, 5'd2, 5'd12, 5'd0, 3'd0);
        dispatch_valid = 1'b1;
        repeat (4) begin
            #1;
            if (dispatch_ready !== 1'b0) begin
                $display("ERROR dispatch_ready got %h expected 0", dispatch_ready);
                n_err++;
            end
            if (issue_valid !== 1'b1 || issue !== held) begin
                $display("ERROR issue got %h expected %h", issue, held);
                n_err++;
            end
            @(negedge CLK);
        end
        issue_ready = 1'b1;
        wait_issue(got, cyc);
        issue_ready = 1'b0;   // Keep the second ALU op in the slot
        send_dispatch(dispatch);
        issue_ready = 1'b1;
        wait_issue(got, cyc);
        if (got.op !== 8'h62) begin
            $display("ERROR issue.op got %h expected 62", got.op);
            n_err++;
        end
        wait_issue(got, cyc);
        if (got.op !== 8'h63) begin
            $display("ERROR issue.op got %h expected 63", got.op);
            n_err++;
        end
    endtask

    initial begin
        int n;
        dispatch_valid = 1'b0;
        dispatch = '0;
        wb = '0;
        issue_ready = 1'b1;
        rng = 32'h94577620;
        n_err = 0;
        n_timeout = 0;
        n = 0;
        while (nRST !== 1'b1 && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (nRST !== 1'b1) begin
            $display("Reset was never released");
            n_timeout++;
        end
        @(negedge CLK);
        test_reset();
        test_operands();
        test_tag_wait();
        test_oldest_first();
        test_backpressure();
        $display("Checks done: %0d value errors, %0d timeouts, %0d assertion failures",
            n_err, n_timeout, UUT.u_sva.n_fail);
        if (n_err == 0 && n_timeout == 0 && UUT.u_sva.n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* issue_top.f */
src/issue_pkg.sv
src/regfile.sv
src/fust_scalar.sv
src/fust_matrix.sv
src/oldest_arbiter.sv
src/issue_out.sv
src/issue_top.sv
verif/tb_clock.sv
verif/issue_sva.sv
verif/issue_tb.sv
